// ==== hdl/radar_pkg.sv ====
package radar_pkg;

   // Raw converter width
   localparam int ADC_W = 12;

   localparam int SAMPLE_W = 16;

   // One averaged sample, unsigned
   typedef logic [SAMPLE_W-1:0] sample_t;

   // Sequencer states
   typedef enum logic [2:0] {
      WAIT_LOCK = 3'd0,   // Synth lock plus first ramp
      ACQUIRE   = 3'd1,
      RAMP_WAIT = 3'd2,   // Between ramps of one frame
      DRAIN     = 3'd3,   // Frame FIFO into host buffer
      HOST_WAIT = 3'd4
   } seq_state_e;

endpackage

// ==== hdl/sweep_control.sv ====
module sweep_control #(
   parameter int unsigned SAMPLES_PER_RAMP = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   synth_locked,
   input  logic                   ramp_start,
   input  logic                   adc_valid,
   input  logic                   fifo_full,
   input  logic                   fifo_empty,
   input  logic                   buf_full,
   input  logic                   buf_empty,
   output logic                   acq_en,
   output logic                   fifo_rd,
   output radar_pkg::seq_state_e  state
);

   import radar_pkg::*;

   localparam int CNT_W = $clog2(SAMPLES_PER_RAMP + 1);
   localparam logic [CNT_W-1:0] LAST_SMP = CNT_W'(SAMPLES_PER_RAMP - 1);

   logic [CNT_W-1:0] smp_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= WAIT_LOCK;
         smp_cnt <= '0;
      end else begin
         case (state)
            WAIT_LOCK: begin
               if (synth_locked && ramp_start) begin
                  state <= ACQUIRE;
               end
            end

            ACQUIRE: begin
               if (fifo_full) begin
                  state   <= DRAIN;
                  smp_cnt <= '0;
               end else if (adc_valid) begin
                  if (smp_cnt == LAST_SMP) begin
                     smp_cnt <= '0;
                     state   <= RAMP_WAIT;
                  end else begin
                     smp_cnt <= smp_cnt + 1'b1;
                  end
               end
            end

            RAMP_WAIT: begin
               // Frame complete once the last word lands
               if (fifo_full) begin
                  state <= DRAIN;
               end else if (ramp_start) begin
                  state <= ACQUIRE;
               end
            end

            DRAIN: begin
               if (fifo_empty) begin
                  state <= HOST_WAIT;
               end
            end

            HOST_WAIT: begin
               // Ramp skipped if host still has words pending
               if (ramp_start && buf_empty) begin
                  state <= ACQUIRE;
               end
            end

            default: begin
               state   <= WAIT_LOCK;
               smp_cnt <= '0;
            end
         endcase
      end
   end

   always_comb begin
      acq_en  = (state == ACQUIRE);
      fifo_rd = (state == DRAIN) && !fifo_empty && !buf_full;   // Also the host push
   end

endmodule

// ==== hdl/boxcar_decimator.sv ====
module boxcar_decimator #(
   parameter int unsigned DEC_LG = 2
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         acq_en,
   input  logic                         adc_valid,
   input  logic [radar_pkg::ADC_W-1:0]  adc_data,
   output radar_pkg::sample_t           dec_data,
   output logic                         dec_valid
);

   import radar_pkg::*;

   localparam int SUM_W = ADC_W + DEC_LG;
   localparam int GRP_W = (DEC_LG > 0) ? DEC_LG : 1;
   localparam logic [GRP_W-1:0] GRP_LAST = GRP_W'((1 << DEC_LG) - 1);

   logic [SUM_W-1:0] acc;
   logic [GRP_W-1:0] grp_cnt;
   logic [SUM_W-1:0] acc_next;

   assign acc_next = acc + SUM_W'(adc_data);

   // Group control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc       <= '0;
         grp_cnt   <= '0;
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= 1'b0;
         if (!acq_en) begin
            acc     <= '0;   // Partial group dropped
            grp_cnt <= '0;
         end else if (adc_valid) begin
            if (grp_cnt == GRP_LAST) begin
               acc       <= '0;
               grp_cnt   <= '0;
               dec_valid <= 1'b1;
            end else begin
               acc     <= acc_next;
               grp_cnt <= grp_cnt + 1'b1;
            end
         end
      end
   end

   // Truncated mean of the finished group
   always_ff @(posedge clk) begin
      if (acq_en && adc_valid && grp_cnt == GRP_LAST) begin
         dec_data <= sample_t'(acc_next[SUM_W-1:DEC_LG]);
      end
   end

endmodule

// ==== hdl/sample_fifo.sv ====
module sample_fifo #(
   parameter int unsigned DEPTH = 8,
   parameter type         T     = logic [15:0]
) (
   input  logic clk,
   input  logic rst_n,
   input  logic wr_en,
   input  logic rd_en,
   input  T     wr_data,
   output T     rd_data,
   output logic full,
   output logic empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

   T mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   assign full    = (count == CNT_W'(DEPTH));
   assign empty   = (count == '0);
   assign rd_data = mem[rd_ptr];   // Show-ahead head word

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   no_overflow_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> !full
   ) else $error("write into full FIFO");

   no_underflow_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_en |-> !empty
   ) else $error("read from empty FIFO");

endmodule

// ==== hdl/host_tx.sv ====
module host_tx #(
   parameter int unsigned TX_CREDITS = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push,
   input  radar_pkg::sample_t push_data,
   input  logic               tx_credit,
   output logic               buf_full,
   output logic               buf_empty,
   output logic               tx_valid,
   output radar_pkg::sample_t tx_data
);

   import radar_pkg::*;

   localparam int PTR_W = (TX_CREDITS > 1) ? $clog2(TX_CREDITS) : 1;
   localparam int CNT_W = $clog2(TX_CREDITS + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(TX_CREDITS - 1);
   localparam logic [CNT_W-1:0] CRED_MAX = CNT_W'(TX_CREDITS);

   sample_t buf_mem [TX_CREDITS];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] credits;

   assign buf_full  = (count == CRED_MAX);
   assign buf_empty = (count == '0);

   // Oldest word goes out whenever a credit is held
   assign tx_valid = !buf_empty && (credits != '0);
   assign tx_data  = buf_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         buf_mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CRED_MAX;   // Host grant at start
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (tx_valid) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, tx_valid})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         case ({tx_credit, tx_valid})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   no_push_full_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      push |-> !buf_full
   ) else $error("host buffer pushed while full");

   credit_bound_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      credits <= CRED_MAX
   ) else $error("host returned more credits than granted");

endmodule

// ==== hdl/radar_frontend_top.sv ====
module radar_frontend_top #(
   parameter int unsigned SAMPLES_PER_RAMP = 16,
   parameter int unsigned DEC_LG           = 2,
   parameter int unsigned FRAME_WORDS      = 8,
   parameter int unsigned TX_CREDITS       = 4
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         synth_locked,
   input  logic                         ramp_start,
   input  logic                         adc_valid,
   input  logic                         tx_credit,
   input  logic [radar_pkg::ADC_W-1:0]  adc_data,
   output logic                         tx_valid,
   output radar_pkg::sample_t           tx_data
);

   import radar_pkg::*;

   logic       acq_en;
   logic       fifo_rd;
   logic       fifo_full;
   logic       fifo_empty;
   logic       buf_full;
   logic       buf_empty;
   logic       dec_valid;
   sample_t    dec_data;
   sample_t    rd_data;
   seq_state_e seq_state;

   sweep_control #(
      .SAMPLES_PER_RAMP (SAMPLES_PER_RAMP)
   ) seq_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .synth_locked (synth_locked),
      .ramp_start   (ramp_start),
      .adc_valid    (adc_valid),
      .fifo_full    (fifo_full),
      .fifo_empty   (fifo_empty),
      .buf_full     (buf_full),
      .buf_empty    (buf_empty),
      .acq_en       (acq_en),
      .fifo_rd      (fifo_rd),
      .state        (seq_state)
   );

   boxcar_decimator #(
      .DEC_LG (DEC_LG)
   ) dec_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .acq_en    (acq_en),
      .adc_valid (adc_valid),
      .adc_data  (adc_data),
      .dec_data  (dec_data),
      .dec_valid (dec_valid)
   );

   // Decimator writes straight in, ungated
   sample_fifo #(
      .DEPTH (FRAME_WORDS),
      .T     (sample_t)
   ) fifo_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (dec_valid),
      .rd_en   (fifo_rd),
      .wr_data (dec_data),
      .rd_data (rd_data),
      .full    (fifo_full),
      .empty   (fifo_empty)
   );

   host_tx #(
      .TX_CREDITS (TX_CREDITS)
   ) tx_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (fifo_rd),
      .push_data (rd_data),
      .tx_credit (tx_credit),
      .buf_full  (buf_full),
      .buf_empty (buf_empty),
      .tx_valid  (tx_valid),
      .tx_data   (tx_data)
   );

   // Frame must be complete before the drain starts
   no_late_word_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (seq_state == DRAIN || seq_state == HOST_WAIT) |-> !dec_valid
   ) else $error("decimated word arrived after frame handoff");

endmodule

// ==== verification/radar_frontend_tb.sv ====
module radar_frontend_tb;

   import radar_pkg::*;

   localparam int SAMPLES_PER_RAMP = 16;
   localparam int DEC_LG           = 2;
   localparam int FRAME_WORDS      = 8;
   localparam int TX_CREDITS       = 4;
   localparam int GROUP            = 1 << DEC_LG;
   localparam int WORDS_PER_RAMP   = SAMPLES_PER_RAMP / GROUP;
   localparam int MAX_CYCLES       = 20000;   // Tests need well under 1000 cycles

   logic             clk = 1'b0;
   logic             rst_n;
   logic             synth_locked;
   logic             ramp_start;
   logic             adc_valid;
   logic             tx_credit;
   logic [ADC_W-1:0] adc_data;
   logic             tx_valid;
   sample_t          tx_data;

   logic [ADC_W-1:0] ramp_smp [SAMPLES_PER_RAMP];
   sample_t          expect_q [$];
   sample_t          exp_word;
   integer           seed         = 99;
   int               words_seen   = 0;
   int               host_credits = TX_CREDITS;
   int               credit_req   = 0;
   bit               auto_credit  = 1'b0;
   int               cycles       = 0;

   radar_frontend_top #(
      .SAMPLES_PER_RAMP (SAMPLES_PER_RAMP),
      .DEC_LG           (DEC_LG),
      .FRAME_WORDS      (FRAME_WORDS),
      .TX_CREDITS       (TX_CREDITS)
   ) dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .synth_locked (synth_locked),
      .ramp_start   (ramp_start),
      .adc_valid    (adc_valid),
      .tx_credit    (tx_credit),
      .adc_data     (adc_data),
      .tx_valid     (tx_valid),
      .tx_data      (tx_data)
   );

   always #20 clk = ~clk;

   task automatic fail_run();
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, expected);
         fail_run();
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         fail_run();
      end
   end

   // Host model samples mid-cycle where tx outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (tx_credit) begin
            host_credits++;   // Pulse taken at the last rising edge
         end
         if (tx_valid) begin
            if (host_credits == 0) begin
               $display("Host overrun: word sent at %0t with no credit left", $time);
               fail_run();
            end
            host_credits--;
            if (expect_q.size() == 0) begin
               $display("Unexpected word %0h on tx_data at %0t", tx_data, $time);
               fail_run();
            end
            exp_word = expect_q.pop_front();
            check_value("tx_data", tx_data, exp_word);
            words_seen++;
         end
         if (auto_credit && host_credits < TX_CREDITS) begin
            tx_credit = 1'b1;
         end else if (credit_req > 0) begin
            tx_credit = 1'b1;
            credit_req--;
         end else begin
            tx_credit = 1'b0;
         end
      end
   end

   task automatic fill_known(input int base);
      for (int i = 0; i < SAMPLES_PER_RAMP; i++) begin
         ramp_smp[i] = ADC_W'(base + i * 293);
      end
   endtask

   task automatic fill_random();
      for (int i = 0; i < SAMPLES_PER_RAMP; i++) begin
         ramp_smp[i] = ADC_W'($random(seed));
      end
   endtask

   // Ramp strobe then one sample per cycle; model gets the group means
   task automatic do_ramp(input bit counted);
      int sum;
      if (counted) begin
         for (int g = 0; g < WORDS_PER_RAMP; g++) begin
            sum = 0;
            for (int k = 0; k < GROUP; k++) begin
               sum += ramp_smp[g * GROUP + k];
            end
            expect_q.push_back(sample_t'(sum >> DEC_LG));
         end
      end
      @(negedge clk);
      ramp_start = 1'b1;
      @(negedge clk);
      ramp_start = 1'b0;
      for (int i = 0; i < SAMPLES_PER_RAMP; i++) begin
         adc_valid = 1'b1;
         adc_data  = ramp_smp[i];
         @(negedge clk);
      end
      adc_valid = 1'b0;
   endtask

   task automatic drive_stray_samples(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         adc_valid = 1'b1;
         adc_data  = ADC_W'($random(seed));
      end
      @(negedge clk);
      adc_valid = 1'b0;
   endtask

   task automatic give_credits(input int n);
      @(posedge clk);
      credit_req = credit_req + n;
      while (credit_req != 0) @(posedge clk);
   endtask

   task automatic wait_words(input int target);
      while (words_seen < target) @(posedge clk);
   endtask

   task automatic test_reset_and_lock();
      fill_random();
      do_ramp(1'b0);   // Not locked yet
      drive_stray_samples(5);
      @(negedge clk);
      synth_locked = 1'b1;
      drive_stray_samples(8);   // Locked, but no ramp yet
      repeat (40) @(posedge clk);
      check_value("words_seen", words_seen, 0);
   endtask

   task automatic test_one_frame();
      @(posedge clk);
      auto_credit = 1'b1;
      fill_known(12'h0F0);
      do_ramp(1'b1);
      drive_stray_samples(6);   // Lands in RAMP_WAIT
      fill_known(12'hE10);
      do_ramp(1'b1);
      wait_words(FRAME_WORDS);
      repeat (10) @(posedge clk);
      auto_credit = 1'b0;
      check_value("words_seen", words_seen, FRAME_WORDS);
   endtask

   task automatic test_back_pressure();
      int base;
      base = words_seen;
      fill_known(12'h7A5);
      do_ramp(1'b1);
      fill_known(12'h155);
      do_ramp(1'b1);
      wait_words(base + TX_CREDITS);
      repeat (200) @(posedge clk);
      check_value("words_seen", words_seen, base + TX_CREDITS);
      fill_random();
      do_ramp(1'b0);   // Host buffer still busy so this ramp is skipped
      give_credits(TX_CREDITS);
      wait_words(base + FRAME_WORDS);
      give_credits(TX_CREDITS);
   endtask

   task automatic test_second_frame();
      int base;
      base = words_seen;
      @(posedge clk);
      auto_credit = 1'b1;
      fill_random();
      do_ramp(1'b1);
      fill_random();
      do_ramp(1'b1);
      wait_words(base + FRAME_WORDS);
      repeat (10) @(posedge clk);
      auto_credit = 1'b0;
      check_value("words_seen", words_seen, base + FRAME_WORDS);
   endtask

   initial begin
      rst_n        = 1'b0;
      synth_locked = 1'b0;
      ramp_start   = 1'b0;
      adc_valid    = 1'b0;
      tx_credit    = 1'b0;
      adc_data     = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reset_and_lock();
      test_one_frame();
      test_back_pressure();
      test_second_frame();
      if (expect_q.size() == 0 && words_seen == 3 * FRAME_WORDS) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Words still expected but never sent: %0d", expect_q.size());
         fail_run();
      end
   end

endmodule

// ==== project.f ====
hdl/radar_pkg.sv
hdl/sweep_control.sv
hdl/boxcar_decimator.sv
hdl/sample_fifo.sv
hdl/host_tx.sv
hdl/radar_frontend_top.sv
verification/radar_frontend_tb.sv

// ==== Bender.yml ====
package:
  name: radar_frontend

sources:
  - hdl/radar_pkg.sv
  - hdl/sweep_control.sv
  - hdl/boxcar_decimator.sv
  - hdl/sample_fifo.sv
  - hdl/host_tx.sv
  - hdl/radar_frontend_top.sv
  - target: test
    files:
      - verification/radar_frontend_tb.sv
